// File: Bender.yml
package:
  name: fe_frontend

sources:
  - frontend_pkg.sv
  - fe_skid_buf.sv
  - fe_pcgen.sv
  - fe_fetch.sv
  - fe_decoder.sv
  - fe_decode_stage.sv
  - fe_fifo.sv
  - fe_frontend.sv
  - target: simulation
    files:
      - tb_frontend.sv

// File: fe_decode_stage.sv
`timescale 1ns/100ps

module fe_decode_stage (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            redirect_i,
  input  logic                            valid_i,
  output logic                            ready_o,
  input  frontend_pkg::addr_t             pc_i,
  input  frontend_pkg::group_t            group_i,
  input  frontend_pkg::slot_mask_t        mask_i,
  input  frontend_pkg::epoch_t            epoch_i,
  output logic                            valid_o,
  input  logic                            ready_i,
  output frontend_pkg::addr_t       [1:0] pc_o,
  output frontend_pkg::inst_t       [1:0] inst_o,
  output frontend_pkg::inst_class_e [1:0] class_o,
  output frontend_pkg::reg_idx_t    [1:0] rd_o,
  output frontend_pkg::slot_mask_t        mask_o
);

  import frontend_pkg::*;

  logic       valid_q;
  epoch_t     epoch_q;
  addr_t      pc_q;
  group_t     group_q;
  slot_mask_t mask_q;

  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign mask_o  = mask_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
      epoch_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      valid_q <= 1'b0;
      epoch_q <= ~epoch_q;
    end
    else if (ready_o)
    begin
      // stale items from before the last redirect die here
      valid_q <= valid_i && (epoch_i == epoch_q);
    end
  end

  always_ff @(posedge clk)
  begin
    if (ready_o && valid_i)
    begin
      pc_q    <= pc_i;
      group_q <= group_i;
      mask_q  <= mask_i;
    end
  end

  assign pc_o[0] = pc_q;
  assign pc_o[1] = pc_q + 32'd4;

  for (genvar i = 0; i < 2; i++)
  begin : gen_slot
    assign inst_o[i] = group_q[32*i +: 32];

    fe_decoder fe_decoder_inst (
      .inst_i  (group_q[32*i +: 32]),
      .class_o (class_o[i]),
      .rd_o    (rd_o[i])
    );
  end

endmodule

// File: fe_decoder.sv
`timescale 1ns/100ps

module fe_decoder (
  input  frontend_pkg::inst_t       inst_i,
  output frontend_pkg::inst_class_e class_o,
  output frontend_pkg::reg_idx_t    rd_o
);

  import frontend_pkg::*;

  logic [6:0] opcode;

  assign opcode = inst_i[6:0];

  always_comb
  begin
    class_o = CLS_ILLEGAL;
    // compressed encodings are not supported
    if (inst_i[1:0] == 2'b11)
    begin
      case (opcode)
        OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC:
        begin
          class_o = CLS_ALU;
        end
        OPC_LOAD:
        begin
          class_o = CLS_LOAD;
        end
        OPC_STORE:
        begin
          class_o = CLS_STORE;
        end
        OPC_BRANCH:
        begin
          class_o = CLS_BRANCH;
        end
        OPC_JAL, OPC_JALR:
        begin
          class_o = CLS_JUMP;
        end
        OPC_SYSTEM:
        begin
          class_o = CLS_SYSTEM;
        end
        default:
        begin
          class_o = CLS_ILLEGAL;
        end
      endcase
    end
  end

  // no destination register for these
  always_comb
  begin
    if (class_o == CLS_STORE || class_o == CLS_BRANCH || class_o == CLS_ILLEGAL)
    begin
      rd_o = '0;
    end
    else
    begin
      rd_o = inst_i[11:7];
    end
  end

endmodule

// File: fe_fetch.sv
`timescale 1ns/100ps

module fe_fetch (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush_i,
  input  logic                     valid_i,
  output logic                     ready_o,
  input  frontend_pkg::addr_t      pc_i,
  input  frontend_pkg::epoch_t     epoch_i,
  output logic                     imem_req_o,
  output frontend_pkg::addr_t      imem_addr_o,
  input  frontend_pkg::group_t     imem_rdata_i,
  output logic                     valid_o,
  input  logic                     ready_i,
  output frontend_pkg::addr_t      pc_o,
  output frontend_pkg::group_t     group_o,
  output frontend_pkg::slot_mask_t mask_o,
  output frontend_pkg::epoch_t     epoch_o
);

  import frontend_pkg::*;

  logic       accept;
  logic       pend_q;
  addr_t      pend_pc_q;
  epoch_t     pend_epoch_q;
  logic       out_valid_q;
  group_t     aligned;
  slot_mask_t aligned_mask;

  // one request in flight, and only into a free output register
  assign ready_o     = !pend_q && (!out_valid_q || ready_i);
  assign accept      = valid_i && ready_o && !flush_i;
  assign imem_req_o  = accept;
  assign imem_addr_o = {pc_i[31:3], 3'b000};

  // upper-half entry moves instruction 1 into slot 0
  always_comb
  begin
    if (pend_pc_q[2])
    begin
      aligned      = {32'h0000_0000, imem_rdata_i[63:32]};
      aligned_mask = 2'b01;
    end
    else
    begin
      aligned      = imem_rdata_i;
      aligned_mask = 2'b11;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      pend_q      <= 1'b0;
      out_valid_q <= 1'b0;
    end
    else
    begin
      pend_q <= accept;
      if (pend_q)
      begin
        out_valid_q <= 1'b1;
      end
      else if (ready_i)
      begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pend_pc_q    <= pc_i;
      pend_epoch_q <= epoch_i;
    end
    // response is valid for this cycle only
    if (pend_q)
    begin
      pc_o    <= pend_pc_q;
      group_o <= aligned;
      mask_o  <= aligned_mask;
      epoch_o <= pend_epoch_q;
    end
  end

  assign valid_o = out_valid_q;

endmodule

// File: fe_fifo.sv
`timescale 1ns/100ps

module fe_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  // head entry is visible without a read cycle
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop)
      begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      if (push && !pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop && !push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: fe_frontend.sv
`timescale 1ns/100ps

module fe_frontend #(
  parameter frontend_pkg::addr_t RESET_PC   = 32'h0000_1000,
  parameter int unsigned         FIFO_DEPTH = 4
) (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     redirect_i,
  input  frontend_pkg::addr_t                                      redirect_pc_i,
  output logic                                                     imem_req_o,
  output frontend_pkg::addr_t                                      imem_addr_o,
  input  frontend_pkg::group_t                                     imem_rdata_i,
  output logic                                                     pkg_valid_o,
  input  logic                                                     pkg_ready_i,
  output frontend_pkg::slot_mask_t                                 pkg_mask_o,
  output frontend_pkg::addr_t [1:0]                                pkg_pc_o,
  output frontend_pkg::inst_t [1:0]                                pkg_inst_o,
  output logic [1:0][$bits(frontend_pkg::inst_class_e)-1:0]        pkg_class_o,
  output frontend_pkg::reg_idx_t [1:0]                             pkg_rd_o
);

  import frontend_pkg::*;

  localparam int unsigned PC_W  = $bits(addr_t) + $bits(epoch_t);
  localparam int unsigned GRP_W = $bits(addr_t) + $bits(group_t) + $bits(slot_mask_t)
                                  + $bits(epoch_t);
  localparam int unsigned PKT_W = $bits(slot_mask_t)
                                  + 2 * ($bits(addr_t) + $bits(inst_t)
                                  + $bits(inst_class_e) + $bits(reg_idx_t));

  // pc generator to skid a
  logic   pg_valid;
  logic   pg_ready;
  addr_t  pg_pc;
  epoch_t pg_epoch;

  // skid a to fetch
  logic   fa_valid;
  logic   fa_ready;
  addr_t  fa_pc;
  epoch_t fa_epoch;

  // fetch to skid b
  logic       ft_valid;
  logic       ft_ready;
  addr_t      ft_pc;
  group_t     ft_group;
  slot_mask_t ft_mask;
  epoch_t     ft_epoch;

  // skid b to decode
  logic       sb_valid;
  logic       sb_ready;
  addr_t      sb_pc;
  group_t     sb_group;
  slot_mask_t sb_mask;
  epoch_t     sb_epoch;

  // decode to fifo
  logic                  dec_valid;
  logic                  dec_ready;
  addr_t       [1:0]     dec_pc;
  inst_t       [1:0]     dec_inst;
  inst_class_e [1:0]     dec_class;
  reg_idx_t    [1:0]     dec_rd;
  slot_mask_t            dec_mask;

  fe_pcgen #(
    .RESET_PC (RESET_PC)
  ) fe_pcgen_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .valid_o       (pg_valid),
    .ready_i       (pg_ready),
    .pc_o          (pg_pc),
    .epoch_o       (pg_epoch)
  );

  fe_skid_buf #(
    .WIDTH (PC_W)
  ) fe_skid_a_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (redirect_i),
    .valid_i (pg_valid),
    .ready_o (pg_ready),
    .data_i  ({pg_pc, pg_epoch}),
    .valid_o (fa_valid),
    .ready_i (fa_ready),
    .data_o  ({fa_pc, fa_epoch})
  );

  fe_fetch fe_fetch_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .valid_i      (fa_valid),
    .ready_o      (fa_ready),
    .pc_i         (fa_pc),
    .epoch_i      (fa_epoch),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .imem_rdata_i (imem_rdata_i),
    .valid_o      (ft_valid),
    .ready_i      (ft_ready),
    .pc_o         (ft_pc),
    .group_o      (ft_group),
    .mask_o       (ft_mask),
    .epoch_o      (ft_epoch)
  );

  fe_skid_buf #(
    .WIDTH (GRP_W)
  ) fe_skid_b_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (redirect_i),
    .valid_i (ft_valid),
    .ready_o (ft_ready),
    .data_i  ({ft_pc, ft_group, ft_mask, ft_epoch}),
    .valid_o (sb_valid),
    .ready_i (sb_ready),
    .data_o  ({sb_pc, sb_group, sb_mask, sb_epoch})
  );

  fe_decode_stage fe_decode_stage_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),
    .valid_i    (sb_valid),
    .ready_o    (sb_ready),
    .pc_i       (sb_pc),
    .group_i    (sb_group),
    .mask_i     (sb_mask),
    .epoch_i    (sb_epoch),
    .valid_o    (dec_valid),
    .ready_i    (dec_ready),
    .pc_o       (dec_pc),
    .inst_o     (dec_inst),
    .class_o    (dec_class),
    .rd_o       (dec_rd),
    .mask_o     (dec_mask)
  );

  fe_fifo #(
    .WIDTH (PKT_W),
    .DEPTH (FIFO_DEPTH)
  ) fe_fifo_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (redirect_i),
    .valid_i (dec_valid),
    .ready_o (dec_ready),
    .data_i  ({dec_mask, dec_pc, dec_inst, dec_class, dec_rd}),
    .valid_o (pkg_valid_o),
    .ready_i (pkg_ready_i),
    .data_o  ({pkg_mask_o, pkg_pc_o, pkg_inst_o, pkg_class_o, pkg_rd_o})
  );

endmodule

// File: fe_pcgen.sv
`timescale 1ns/100ps

module fe_pcgen #(
  parameter frontend_pkg::addr_t RESET_PC = 32'h0000_1000
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 redirect_i,
  input  frontend_pkg::addr_t  redirect_pc_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output frontend_pkg::addr_t  pc_o,
  output frontend_pkg::epoch_t epoch_o
);

  import frontend_pkg::*;

  logic   valid_q;
  addr_t  pc_q;
  epoch_t epoch_q;

  assign valid_o = valid_q;
  assign pc_o    = pc_q;
  assign epoch_o = epoch_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
      pc_q    <= RESET_PC;
      epoch_q <= 1'b0;
    end
    else if (redirect_i)
    begin
      // target may sit in the upper half of a group
      valid_q <= 1'b1;
      pc_q    <= redirect_pc_i;
      epoch_q <= ~epoch_q;
    end
    else
    begin
      valid_q <= 1'b1;
      if (valid_q && ready_i)
      begin
        // next 8-byte group
        pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
      end
    end
  end

endmodule

// File: fe_skid_buf.sv
`timescale 1ns/100ps

module fe_skid_buf #(
  parameter int unsigned WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  logic             ready_q;
  logic [WIDTH-1:0] spare_q;

  // a low ready means the spare register holds an item
  assign ready_o = ready_q;
  assign valid_o = valid_i || !ready_q;
  assign data_o  = ready_q ? data_i : spare_q;

  always_ff @(posedge clk)
  begin
    if (!rst_n || flush_i)
    begin
      ready_q <= 1'b1;
    end
    else
    begin
      ready_q <= ready_i || !valid_o;
    end
  end

  // follows the input while empty, freezes once stalled
  always_ff @(posedge clk)
  begin
    if (ready_q)
    begin
      spare_q <= data_i;
    end
  end

endmodule

// File: flist.f
frontend_pkg.sv
fe_skid_buf.sv
fe_pcgen.sv
fe_fetch.sv
fe_decoder.sv
fe_decode_stage.sv
fe_fifo.sv
fe_frontend.sv
tb_frontend.sv

// File: frontend_pkg.sv
package frontend_pkg;

  // byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // two instruction slots, slot 0 in the low half
  typedef logic [63:0] group_t;

  // one valid bit per slot
  typedef logic [1:0] slot_mask_t;

  // redirect generation tag
  typedef logic epoch_t;

  typedef logic [4:0] reg_idx_t;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JUMP,
    CLS_SYSTEM,
    CLS_ILLEGAL
  } inst_class_e;

  // rv32i major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

endpackage

// File: tb_frontend.sv
`timescale 1ns/100ps

module tb_frontend;

  import frontend_pkg::*;

  localparam addr_t RESET_PC = 32'h0000_1000;
  localparam int    NUM_ROWS = 6;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       redirect_i;
  addr_t                                      redirect_pc_i;
  logic                                       imem_req_o;
  addr_t                                      imem_addr_o;
  group_t                                     imem_rdata_i;
  logic                                       pkg_valid_o;
  logic                                       pkg_ready_i;
  slot_mask_t                                 pkg_mask_o;
  addr_t [1:0]                                pkg_pc_o;
  inst_t [1:0]                                pkg_inst_o;
  logic [1:0][$bits(inst_class_e)-1:0]        pkg_class_o;
  reg_idx_t [1:0]                             pkg_rd_o;

  group_t      mem_q [64];
  inst_t       base_words [16];
  inst_class_e base_class [16];
  logic        mem_req;
  addr_t       mem_addr;

  // stimulus table, one entry per test
  string       row_name [NUM_ROWS];
  logic        row_redir [NUM_ROWS];
  addr_t       row_target [NUM_ROWS];
  int          row_count [NUM_ROWS];
  int          row_stall [NUM_ROWS];
  logic        row_rand [NUM_ROWS];

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = 1000;
  logic [31:0] lfsr_q;
  addr_t       exp_pc;

  fe_frontend #(
    .RESET_PC   (RESET_PC),
    .FIFO_DEPTH (4)
  ) fe_frontend_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .imem_rdata_i  (imem_rdata_i),
    .pkg_valid_o   (pkg_valid_o),
    .pkg_ready_i   (pkg_ready_i),
    .pkg_mask_o    (pkg_mask_o),
    .pkg_pc_o      (pkg_pc_o),
    .pkg_inst_o    (pkg_inst_o),
    .pkg_class_o   (pkg_class_o),
    .pkg_rd_o      (pkg_rd_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // one-cycle read port, address taken at the edge
  always @(posedge clk)
  begin
    mem_req  = imem_req_o;
    mem_addr = imem_addr_o;
    #1;
    if (mem_req)
    begin
      imem_rdata_i = mem_q[mem_addr[8:3]];
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > limit)
    begin
      $display("timeout after %0d cycles, packet stream stalled, %0d errors", cycles, errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // index mixed into funct7 and rd so every word differs
  function automatic inst_t word_at(input logic [6:0] w);
    return base_words[w[3:0]] ^ {w, 13'd0, w[4:0], 7'd0};
  endfunction

  function automatic reg_idx_t expect_rd(input inst_t word, input inst_class_e cls);
    if (cls == CLS_STORE || cls == CLS_BRANCH || cls == CLS_ILLEGAL)
    begin
      return 5'd0;
    end
    return word[11:7];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks = checks + 1;
    if (expected !== actual)
    begin
      errors = errors + 1;
      $display("[ERROR] %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic set_row(input int idx, input string name, input logic redir,
                         input addr_t target, input int count, input int stall,
                         input logic rnd);
    row_name[idx]   = name;
    row_redir[idx]  = redir;
    row_target[idx] = target;
    row_count[idx]  = count;
    row_stall[idx]  = stall;
    row_rand[idx]   = rnd;
  endtask

  task automatic fill_memory();
    // alu, load, store, branch, jump, system and illegal words
    base_words[0]  = 32'h002081b3;
    base_words[1]  = 32'h00a00093;
    base_words[2]  = 32'h123452b7;
    base_words[3]  = 32'h00001317;
    base_words[4]  = 32'h0000a383;
    base_words[5]  = 32'h0070a223;
    base_words[6]  = 32'h00208463;
    base_words[7]  = 32'h008000ef;
    base_words[8]  = 32'h000080e7;
    base_words[9]  = 32'h00000073;
    base_words[10] = 32'h30529073;
    base_words[11] = 32'h0000000b;
    base_words[12] = 32'h00004501;
    base_words[13] = 32'h00000000;
    base_words[14] = 32'h00b50023;
    base_words[15] = 32'hfe209ee3;
    // class of each base word, set by hand
    base_class[0]  = CLS_ALU;
    base_class[1]  = CLS_ALU;
    base_class[2]  = CLS_ALU;
    base_class[3]  = CLS_ALU;
    base_class[4]  = CLS_LOAD;
    base_class[5]  = CLS_STORE;
    base_class[6]  = CLS_BRANCH;
    base_class[7]  = CLS_JUMP;
    base_class[8]  = CLS_JUMP;
    base_class[9]  = CLS_SYSTEM;
    base_class[10] = CLS_SYSTEM;
    base_class[11] = CLS_ILLEGAL;
    base_class[12] = CLS_ILLEGAL;
    base_class[13] = CLS_ILLEGAL;
    base_class[14] = CLS_STORE;
    base_class[15] = CLS_BRANCH;
    for (int g = 0; g < 64; g++)
    begin
      mem_q[g] = {word_at(7'(2 * g + 1)), word_at(7'(2 * g))};
    end
  endtask

  task automatic check_packet(input string name);
    slot_mask_t  mask;
    addr_t       slot_pc;
    inst_t       word;
    inst_class_e cls;
    mask = exp_pc[2] ? 2'b01 : 2'b11;
    check_value({name, " mask"}, mask, pkg_mask_o);
    for (int s = 0; s < 2; s++)
    begin
      if (mask[s])
      begin
        slot_pc = exp_pc + 32'(4 * s);
        word    = word_at(slot_pc[8:2]);
        cls     = base_class[slot_pc[5:2]];
        check_value($sformatf("%s pc%0d", name, s), slot_pc, pkg_pc_o[s]);
        check_value($sformatf("%s inst%0d", name, s), word, pkg_inst_o[s]);
        check_value($sformatf("%s class%0d", name, s), cls, pkg_class_o[s]);
        check_value($sformatf("%s rd%0d", name, s), expect_rd(word, cls), pkg_rd_o[s]);
      end
    end
    exp_pc = (exp_pc & ~32'd7) + 32'd8;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    int got;
    int total;
    rst_n         = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    pkg_ready_i   = 1'b0;
    imem_rdata_i  = '0;
    exp_pc        = RESET_PC;
    lfsr_q        = 32'h3db65672;
    set_row(0, "seq_reset", 1'b0, 32'h0000_0000, 6, 0, 1'b0);
    set_row(1, "redir_upper_half", 1'b1, 32'h0000_1014, 4, 0, 1'b0);
    set_row(2, "redir_full_fifo", 1'b1, 32'h0000_1080, 5, 12, 1'b0);
    set_row(3, "random_ready", 1'b0, 32'h0000_0000, 20, 8, 1'b1);
    set_row(4, "redir_random_ready", 1'b1, 32'h0000_10a4, 10, 0, 1'b1);
    set_row(5, "redir_aligned", 1'b1, 32'h0000_1100, 8, 3, 1'b1);
    total = 0;
    for (int r = 0; r < NUM_ROWS; r++)
    begin
      total = total + row_count[r];
    end
    limit = total * 20 + 200;
    fill_memory();

    repeat (10)
    begin
      next_cycle();
      check_value("reset pkg_valid", 1'b0, pkg_valid_o);
      check_value("reset imem_req", 1'b0, imem_req_o);
    end
    rst_n = 1'b1;
    #1;
    check_value("post reset pkg_valid", 1'b0, pkg_valid_o);
    check_value("post reset imem_req", 1'b0, imem_req_o);
    next_cycle();

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      // hold the backend off so older packets pile up
      for (int i = 0; i < row_stall[r]; i++)
      begin
        pkg_ready_i = 1'b0;
        next_cycle();
      end
      if (row_redir[r])
      begin
        redirect_i    = 1'b1;
        redirect_pc_i = row_target[r];
        pkg_ready_i   = 1'b0;
        next_cycle();
        redirect_i = 1'b0;
        exp_pc     = row_target[r];
      end
      got = 0;
      while (got < row_count[r])
      begin
        if (row_rand[r])
        begin
          lfsr_q      = lfsr_next(lfsr_q);
          pkg_ready_i = lfsr_q[0];
        end
        else
        begin
          pkg_ready_i = 1'b1;
        end
        // transfer happens at the coming edge
        if (pkg_valid_o && pkg_ready_i)
        begin
          check_packet($sformatf("%s pkt%0d", row_name[r], got));
          got = got + 1;
        end
        next_cycle();
      end
      pkg_ready_i = 1'b0;
    end

    $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
